// File: sim.f
+incdir+.
alu_pkg.sv
mpy_if.sv
alu_mpy.sv
alu_ops.sv
alu_top.sv
tb_alu_properties.sv
tb_alu.sv

// File: Bender.yml
package:
  name: alu_exec

sources:
  - include_dirs:
      - .
    files:
      - alu_pkg.sv
      - mpy_if.sv
      - alu_mpy.sv
      - alu_ops.sv
      - alu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_alu_properties.sv
      - tb_alu.sv

// File: tb_alu.sv
/*
 * Testbench for the integer execution unit
 * Directed then random ops, one at a time after each valid;
 * the bound checker judges results and timing
 */
`timescale 1ns/1ps
`include "alu_consts.svh"

module tb_alu import alu_pkg::*;
();

	localparam int N_DIRECTED = 52;
	localparam int N_RANDOM   = 300;
	localparam int MAX_CYCLES = 20 + 6 * (N_DIRECTED + N_RANDOM);	// Worst op is 6 cycles

	logic                  i_clk = 1'b0;
	logic                  i_reset;
	logic                  i_stb;
	alu_op_e               i_op;
	logic [`ALU_WIDTH-1:0] i_a;
	logic [`ALU_WIDTH-1:0] i_b;
	logic [`ALU_WIDTH-1:0] o_c;
	alu_flags_t            o_f;
	logic                  o_valid;
	logic                  o_busy;
	integer                seed = 32'hd3f55715;
	int                    cycles = 0;

	always #20 i_clk = ~i_clk;	// 40 ns period

	alu_top dut
	(
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_stb   (i_stb),
		.i_op    (i_op),
		.i_a     (i_a),
		.i_b     (i_b),
		.o_c     (o_c),
		.o_f     (o_f),
		.o_valid (o_valid),
		.o_busy  (o_busy)
	);

	// One strobe, then hold until the result shows
	task automatic run_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b);
		@(posedge i_clk);
		i_stb <= 1'b1;
		i_op  <= op;
		i_a   <= a;
		i_b   <= b;
		@(posedge i_clk);
		i_stb <= 1'b0;
		do
			@(posedge i_clk);
		while (!o_valid);	// One cycle on, four for a multiply
	endtask

	//////////////////////////////
	// Failure and timeout watch
	//////////////////////////////

	always @(negedge i_clk)
	begin
		cycles++;
		if (dut.u_props.fail_kind != 0 || cycles > MAX_CYCLES)
		begin
			if (cycles > MAX_CYCLES)
				$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			else if (dut.u_props.fail_kind == 1)
			begin
				if (o_c !== dut.u_props.exp_c)
					$display("** Error at %0t ns: o_c expected %h, got %h",
						$time, dut.u_props.exp_c, o_c);
				if (o_f !== dut.u_props.exp_f)
					$display("** Error at %0t ns: o_f expected %b, got %b",
						$time, dut.u_props.exp_f, o_f);
			end
			else
				$display("Handshake failure at %0t ns: valid or busy out of step", $time);
			$display("SIMULATION FAILED");
			$fatal(1, "Run stopped at the first failure");
		end
	end

	//////////////////////////////
	// Stimulus
	//////////////////////////////

	initial
	begin
		logic [31:0] sh_amt [5];
		logic [31:0] sh_a [2];
		logic [31:0] r_op;
		logic [31:0] r_a;
		logic [31:0] r_b;
		sh_amt = '{32'd0, 32'd31, 32'd32, 32'd33, 32'd100};	// Edges of the shifter
		sh_a   = '{32'h8000_0001, 32'h4000_0002};
		i_reset <= 1'b1;
		i_stb   <= 1'b0;
		i_op    <= OP_MOV;
		i_a     <= '0;
		i_b     <= '0;
		repeat (3) @(posedge i_clk);
		i_reset <= 1'b0;

		// Arithmetic and logic, with borrow, carry, overflow and zero
		run_op(OP_SUB, 32'd5, 32'd3);
		run_op(OP_SUB, 32'd3, 32'd5);
		run_op(OP_SUB, 32'd7, 32'd7);
		run_op(OP_SUB, 32'h8000_0000, 32'd1);
		run_op(OP_SUB, 32'h7fff_ffff, 32'hffff_ffff);
		run_op(OP_AND, 32'hf0f0_f0f0, 32'h0ff0_0ff0);
		run_op(OP_ADD, 32'hffff_ffff, 32'd1);
		run_op(OP_ADD, 32'h7fff_ffff, 32'd1);
		run_op(OP_ADD, 32'h8000_0000, 32'h8000_0000);
		run_op(OP_OR, 32'h1234_0000, 32'h0000_5678);
		run_op(OP_XOR, 32'ha5a5_a5a5, 32'ha5a5_a5a5);

		for (int i = 0; i < 2; i++)
		begin
			for (int k = 0; k < 5; k++)
			begin
				run_op(OP_LSR, sh_a[i], sh_amt[k]);
				run_op(OP_LSL, sh_a[i], sh_amt[k]);
				run_op(OP_ASR, sh_a[i], sh_amt[k]);
			end
		end

		run_op(OP_BREV, 32'd0, 32'h1234_5678);
		run_op(OP_LDILO, 32'hdead_beef, 32'h1234_cafe);
		run_op(OP_MOV, 32'h1111_1111, 32'h8765_4321);
		run_op(alu_op_e'(4'd14), 32'h2222_2222, 32'd0);	// Spare codes act as move
		run_op(alu_op_e'(4'd15), 32'h3333_3333, 32'h0bad_f00d);

		// Multiplies, mixed signs and the most negative pair
		run_op(OP_MPY, 32'hffff_fff0, 32'h0000_1234);
		run_op(OP_MPYHU, 32'hffff_fff0, 32'h0000_1234);
		run_op(OP_MPYHS, 32'hffff_fff0, 32'h0000_1234);
		run_op(OP_MPY, 32'h8000_0000, 32'h8000_0000);
		run_op(OP_MPYHU, 32'h8000_0000, 32'h8000_0000);
		run_op(OP_MPYHS, 32'h8000_0000, 32'h8000_0000);

		for (int i = 0; i < N_RANDOM; i++)
		begin
			r_op = $random(seed);
			r_a  = $random(seed);
			r_b  = $random(seed);
			if (r_op[4])
				r_b = r_b & 32'h3f;	// Short shift counts half the time
			run_op(alu_op_e'(r_op[3:0]), r_a, r_b);
		end

		repeat (2) @(posedge i_clk);
		if (dut.u_props.fail_kind == 0)
		begin
			$display("SIMULATION PASSED");
			$finish;
		end
		else
		begin
			$display("SIMULATION FAILED");
			$fatal(1, "Checker flagged a failure at the end of the run");
		end
	end

endmodule

// File: tb_alu_properties.sv
/*
 * Bound checker for the integer execution unit
 * Captures each strobe, predicts result and flags from the
 * opcode rules, and checks valid and busy timing
 */
`timescale 1ns/1ps
`include "alu_consts.svh"

module tb_alu_properties import alu_pkg::*;
(
	input logic                    i_clk,
	input logic                    i_reset,
	input logic                    i_stb,
	input logic [`ALU_OP_BITS-1:0] i_op,
	input logic [`ALU_WIDTH-1:0]   i_a,
	input logic [`ALU_WIDTH-1:0]   i_b,
	input logic [`ALU_WIDTH-1:0]   o_c,
	input alu_flags_t              o_f,
	input logic                    o_valid,
	input logic                    o_busy
);

	localparam int W = `ALU_WIDTH;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Returns {flags, result} for one op
	function automatic logic [W+3:0] ref_op(input logic [3:0] op, input logic [W-1:0] a,
		input logic [W-1:0] b);
		logic [2*W-1:0]        t_lsr;	// a in the top half, shifted down
		logic [2*W-1:0]        t_lsl;	// a in the low half, shifted up
		logic signed [2*W-1:0] t_asr;
		logic [2*W-1:0]        p_u;
		logic signed [2*W-1:0] p_s;
		logic [W:0]            sum;
		logic [W-1:0]          r;
		logic                  c;
		logic                  v;
		logic                  ov_op;	// Op that can overflow
		alu_flags_t            f;
		t_lsr = {a, {W{1'b0}}} >> b;	// Bit below the result is the last one out
		t_lsl = {{W{1'b0}}, a} << b;
		t_asr = $signed({a, {W{1'b0}}}) >>> b;
		p_u   = a * b;
		p_s   = $signed(a) * $signed(b);
		sum   = {1'b0, a} + {1'b0, b};
		c     = 1'b0;
		ov_op = 1'b0;
		case (op)
		OP_SUB:   {c, r, ov_op} = {a < b, a - b, a[W-1] != b[W-1]};	// Borrow on a < b
		OP_AND:   r = a & b;
		OP_ADD:   {c, r, ov_op} = {sum, a[W-1] == b[W-1]};
		OP_OR:    r = a | b;
		OP_XOR:   r = a ^ b;
		OP_LSR:   {r, c, ov_op} = {t_lsr[2*W-1:W-1], 1'b1};
		OP_LSL:   {c, r, ov_op} = {t_lsl[W:0], 1'b1};
		OP_ASR:   {r, c} = t_asr[2*W-1:W-1];
		OP_BREV:  r = {<<{b}};
		OP_LDILO: r = {a[W-1:W/2], b[W/2-1:0]};
		OP_MPYHU: r = p_u[2*W-1:W];
		OP_MPYHS: r = p_s[2*W-1:W];
		OP_MPY:   r = p_u[W-1:0];
		default:  r = b;	// MOV and the two spare codes
		endcase
		v = ov_op && (r[W-1] != a[W-1]);
		// True sign of an overflowed sum or difference
		f = '{v: v, n: r[W-1] ^ (v && (op == OP_SUB || op == OP_ADD)), c: c, z: (r == '0)};
		return {f, r};
	endfunction

	//////////////////////////////
	// Expected outcome
	//////////////////////////////

	logic [W-1:0] exp_c;
	alu_flags_t   exp_f;
	logic         exp_mpy;	// Op in flight is a multiply
	logic [2:0]   wait_cnt;	// Cycles to valid, 1 means this cycle
	logic         stb_mpy;
	int           fail_kind = 0;	// 1 result, 2 handshake

	assign stb_mpy = (i_op == OP_MPYHU) || (i_op == OP_MPYHS) || (i_op == OP_MPY);

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			wait_cnt <= '0;
			exp_mpy  <= 1'b0;
		end
		else if (i_stb)
		begin
			{exp_f, exp_c} <= ref_op(i_op, i_a, i_b);
			exp_mpy        <= stb_mpy;
			wait_cnt       <= stb_mpy ? 3'(`ALU_MPY_STAGES + 1) : 3'd1;
		end
		else if (wait_cnt != '0)
			wait_cnt <= wait_cnt - 1'b1;	// Count down to the valid cycle
	end

	task automatic log_failure(input int kind, input string msg);
		fail_kind = kind;
		$error("%s", msg);
	endtask

	//////////////////////////////
	// Properties
	//////////////////////////////

	reset_idle: assert property (@(posedge i_clk) i_reset |=> !o_valid && !o_busy)
	else log_failure(2, "o_valid or o_busy high right after reset");

	valid_busy_excl: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_valid && o_busy))
	else log_failure(2, "o_valid and o_busy high together");

	// Caller error, never queued
	stb_while_busy: assert property (@(posedge i_clk) disable iff (i_reset)
		o_busy |-> !i_stb)
	else log_failure(2, "strobe issued while busy");

	valid_timing: assert property (@(posedge i_clk) disable iff (i_reset)
		o_valid == (wait_cnt == 3'd1))
	else log_failure(2, "o_valid not in the cycle the strobe calls for");

	busy_timing: assert property (@(posedge i_clk) disable iff (i_reset)
		o_busy == (exp_mpy && wait_cnt > 3'd1))
	else log_failure(2, "o_busy not high exactly while a multiply is in flight");

	result_match: assert property (@(posedge i_clk) disable iff (i_reset)
		o_valid |-> (o_c == exp_c) && (o_f == exp_f))
	else log_failure(1, $sformatf("o_c %h o_f %b, expected %h %b", o_c, o_f, exp_c, exp_f));

endmodule

bind alu_top tb_alu_properties u_props
(
	.i_clk   (i_clk),
	.i_reset (i_reset),
	.i_stb   (i_stb),
	.i_op    (i_op),
	.i_a     (i_a),
	.i_b     (i_b),
	.o_c     (o_c),
	.o_f     (o_f),
	.o_valid (o_valid),
	.o_busy  (o_busy)
);

// File: alu_top.sv
/*
 * Integer execution unit top level
 * ALU and pipelined multiplier joined by the multiply channel
 */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_top import alu_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_stb,	// One op per strobe
	input  alu_op_e               i_op,
	input  logic [`ALU_WIDTH-1:0] i_a,
	input  logic [`ALU_WIDTH-1:0] i_b,
	output logic [`ALU_WIDTH-1:0] o_c,
	output alu_flags_t            o_f,
	output logic                  o_valid,
	output logic                  o_busy	// No strobe while high
);

	//////////////////////////////
	// Multiply channel
	//////////////////////////////

	mpy_if u_mpy_if ();

	//////////////////////////////
	// ALU
	//////////////////////////////

	alu_ops u_ops
	(
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_stb   (i_stb),
		.i_op    (i_op),
		.i_a     (i_a),
		.i_b     (i_b),
		.o_c     (o_c),
		.o_f     (o_f),
		.o_valid (o_valid),
		.o_busy  (o_busy),
		.mpy     (u_mpy_if.requester)
	);

	//////////////////////////////
	// Multiplier
	//////////////////////////////

	alu_mpy u_mpy
	(
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.mpy     (u_mpy_if.unit)
	);

endmodule

// File: alu_ops.sv
/*
 * Registered integer ALU
 * One operation per strobe, result and flags the next cycle;
 * multiplies go out to the multiplier and hold busy until done
 */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_ops import alu_pkg::*;
(
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  logic                  i_stb,
	input  alu_op_e               i_op,
	input  logic [`ALU_WIDTH-1:0] i_a,
	input  logic [`ALU_WIDTH-1:0] i_b,
	output logic [`ALU_WIDTH-1:0] o_c,
	output alu_flags_t            o_f,
	output logic                  o_valid,
	output logic                  o_busy,
	mpy_if.requester              mpy
);

	localparam int W  = `ALU_WIDTH;
	localparam int SH = $clog2(W);	// Shift amount bits within a word

	//////////////////////////////
	// Shifter
	//////////////////////////////

	logic              sh_big;	// Amount above the word width
	logic              sh_full;	// Amount exactly the word width
	logic [W:0]        lsr_res;	// {result, carry}
	logic [W:0]        lsl_res;	// {carry, result}
	logic [W:0]        asr_res;	// {result, carry}
	logic signed [W:0] asr_in;

	assign sh_big  = (|i_b[W-1:SH+1]) || (i_b[SH] && (i_b[SH-1:0] != '0));
	assign sh_full = i_b[SH];
	assign asr_in  = {i_a, 1'b0};	// Extra low bit catches shift-out

	always_comb
	begin
		// Logical right
		if (sh_big)
			lsr_res = '0;
		else if (sh_full)
			lsr_res = {{W{1'b0}}, i_a[W-1]};	// Top bit lands in carry
		else
			lsr_res = {i_a, 1'b0} >> i_b[SH-1:0];

		// Left
		if (sh_big)
			lsl_res = '0;
		else if (sh_full)
			lsl_res = {i_a[0], {W{1'b0}}};
		else
			lsl_res = {1'b0, i_a} << i_b[SH-1:0];

		// Arithmetic right, 32 and up fill with sign
		if (sh_big || sh_full)
			asr_res = {(W+1){i_a[W-1]}};
		else
			asr_res = asr_in >>> i_b[SH-1:0];
	end

	// Bit reversal of b
	logic [W-1:0] brev_res;

	always_comb
	begin
		for (int k = 0; k < W; k++)
			brev_res[k] = i_b[W-1-k];
	end

	//////////////////////////////
	// Multiply request
	//////////////////////////////

	logic      is_mpy;
	mpy_kind_e r_kind;	// Held until done

	assign is_mpy = (i_op == OP_MPYHU) || (i_op == OP_MPYHS) || (i_op == OP_MPY);

	assign mpy.start = i_stb && is_mpy;
	assign mpy.kind  = mpy_kind_e'(i_op[1:0]);	// Opcode low bits pick the half
	assign mpy.a     = i_a;
	assign mpy.b     = i_b;

	always_ff @(posedge i_clk)
	begin
		if (mpy.start)
			r_kind <= mpy.kind;
	end

	//////////////////////////////
	// Result and flag pre-logic
	//////////////////////////////

	logic r_c;		// Registered carry
	logic pre_sign;	// Sign of a at the strobe
	logic set_ovfl;	// Op can overflow
	logic keep_sgn;	// Op flips N on overflow

	always_ff @(posedge i_clk)
	begin
		if (i_stb)
		begin
			pre_sign <= i_a[W-1];
			set_ovfl <= ((i_op == OP_SUB) && (i_a[W-1] != i_b[W-1]))
				|| ((i_op == OP_ADD) && (i_a[W-1] == i_b[W-1]))
				|| (i_op == OP_LSL) || (i_op == OP_LSR);
			keep_sgn <= ((i_op == OP_SUB) && (i_a[W-1] != i_b[W-1]))
				|| ((i_op == OP_ADD) && (i_a[W-1] == i_b[W-1]));
			r_c <= 1'b0;	// Only arithmetic and shifts set it
			case (i_op)
			OP_SUB:   {r_c, o_c} <= {1'b0, i_a} - {1'b0, i_b};	// Borrow out
			OP_AND:   o_c <= i_a & i_b;
			OP_ADD:   {r_c, o_c} <= {1'b0, i_a} + {1'b0, i_b};
			OP_OR:    o_c <= i_a | i_b;
			OP_XOR:   o_c <= i_a ^ i_b;
			OP_LSR:   {o_c, r_c} <= lsr_res;
			OP_LSL:   {r_c, o_c} <= lsl_res;
			OP_ASR:   {o_c, r_c} <= asr_res;
			OP_BREV:  o_c <= brev_res;
			OP_LDILO: o_c <= {i_a[W-1:W/2], i_b[W/2-1:0]};
			OP_MPYHU, OP_MPYHS, OP_MPY:
				o_c <= o_c;	// Filled in on done
			default:  o_c <= i_b;	// MOV, and 14, 15
			endcase
		end
		else if (mpy.done)
		begin
			r_c <= 1'b0;
			if (r_kind == MPY_LO)
				o_c <= mpy.prod.half.lo;
			else
				o_c <= mpy.prod.half.hi;
		end
	end

	// Flags from the registered result
	logic z, n, v, vx;

	assign z  = (o_c == '0);
	assign n  = o_c[W-1];
	assign v  = set_ovfl && (pre_sign != o_c[W-1]);
	assign vx = keep_sgn && (pre_sign != o_c[W-1]);	// True sign of sum

	assign o_f = '{v: v, n: n ^ vx, c: r_c, z: z};

	//////////////////////////////
	// Handshake
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			o_valid <= 1'b0;
			o_busy  <= 1'b0;
		end
		else
		begin
			o_valid <= (i_stb && !is_mpy) || mpy.done;
			if (mpy.start)
				o_busy <= 1'b1;	// Hold off new strobes
			else if (mpy.done)
				o_busy <= 1'b0;	// Drops as valid rises
		end
	end

endmodule

// File: alu_mpy.sv
/*
 * Pipelined 32x32 multiplier
 * Extends both operands by kind, then multiplies over a fixed
 * number of register stages; done marks the product word
 */
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_mpy import alu_pkg::*;
(
	input  logic i_clk,
	input  logic i_reset,
	mpy_if.unit  mpy
);

	localparam int W = `ALU_WIDTH;
	localparam int N = `ALU_MPY_STAGES;	// Start to done, in cycles

	//////////////////////////////
	// Stage 0, operand capture
	//////////////////////////////

	logic signed [W:0] a_x;	// One extra bit for sign or zero
	logic signed [W:0] b_x;
	logic              ext_sgn;

	// Only the signed high product needs sign extension
	assign ext_sgn = (mpy.kind == MPY_HS);

	always_ff @(posedge i_clk)
	begin
		if (mpy.start)
		begin
			a_x <= {ext_sgn & mpy.a[W-1], mpy.a};
			b_x <= {ext_sgn & mpy.b[W-1], mpy.b};
		end
	end

	//////////////////////////////
	// Stage 1 onward, product
	//////////////////////////////

	logic signed [2*W+1:0] full_prod;	// 33x33 signed
	logic [2*W-1:0]        prod_pipe [1:N-1];

	// Low 64 bits are right for both extensions
	assign full_prod = a_x * b_x;

	always_ff @(posedge i_clk)
	begin
		prod_pipe[1] <= full_prod[2*W-1:0];
		// Extra stages just carry the word along
		for (int s = 2; s < N; s++)
			prod_pipe[s] <= prod_pipe[s-1];
	end

	//////////////////////////////
	// Valid bits
	//////////////////////////////

	logic [N-1:0] vld;	// One bit per stage

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			vld <= '0;
		else
			vld <= {vld[N-2:0], mpy.start};	// Shift with the data
	end

	// Last stage drives the answer
	assign mpy.done      = vld[N-1];
	assign mpy.prod.full = prod_pipe[N-1];

endmodule

// File: mpy_if.sv
/*
 * Multiply request channel
 * ALU raises start with the operands, the multiplier answers
 * with a done pulse and the product, no back-pressure
 */
`timescale 1ns/1ps
`include "alu_consts.svh"

interface mpy_if import alu_pkg::*; ();

	logic                  start;	// One-cycle request
	mpy_kind_e             kind;	// High or low, signed or not
	logic [`ALU_WIDTH-1:0] a;
	logic [`ALU_WIDTH-1:0] b;
	logic                  done;	// One-cycle answer
	mpy_prod_u             prod;	// Valid with done

	// ALU side
	modport requester (output start, kind, a, b, input done, prod);

	// Multiplier side
	modport unit (input start, kind, a, b, output done, prod);

endinterface

// File: alu_pkg.sv
/*
 * Integer execution unit types
 * Opcode encoding, condition flags, multiply selector and the
 * multiplier product word with its two views
 */
`include "alu_consts.svh"

package alu_pkg;

	// ALU opcodes, 14 and 15 fall through to move
	typedef enum logic [`ALU_OP_BITS-1:0] {
		OP_SUB   = 4'd0,	// Also compare
		OP_AND   = 4'd1,
		OP_ADD   = 4'd2,
		OP_OR    = 4'd3,
		OP_XOR   = 4'd4,
		OP_LSR   = 4'd5,
		OP_LSL   = 4'd6,
		OP_ASR   = 4'd7,
		OP_BREV  = 4'd8,
		OP_LDILO = 4'd9,	// Load immediate into low half
		OP_MPYHU = 4'd10,
		OP_MPYHS = 4'd11,
		OP_MPY   = 4'd12,
		OP_MOV   = 4'd13
	} alu_op_e;

	// Condition flags, order is fixed by the flag register layout
	typedef struct packed {
		logic v;	// Overflow
		logic n;	// Negative
		logic c;	// Carry or borrow
		logic z;	// Zero
	} alu_flags_t;

	// Multiply selector, equal to the low two opcode bits
	typedef enum logic [1:0] {
		MPY_LO = 2'b00,	// Low word
		MPY_HU = 2'b10,	// High word, unsigned
		MPY_HS = 2'b11	// High word, signed
	} mpy_kind_e;

	// Full product, or split into its halves
	typedef union packed {
		logic [2*`ALU_WIDTH-1:0] full;
		struct packed {
			logic [`ALU_WIDTH-1:0] hi;
			logic [`ALU_WIDTH-1:0] lo;
		} half;
	} mpy_prod_u;

endpackage

// File: alu_consts.svh
/*
 * Integer execution unit constants
 * Data width, multiplier pipeline depth and opcode field width
 * shared by the package, the ALU and the multiplier
 */
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

//////////////////////////////
// Datapath
//////////////////////////////

// Operand and result width
`define ALU_WIDTH 32

// Register stages inside the multiplier, 2 to 5 are supported
`define ALU_MPY_STAGES 3

//////////////////////////////
// Opcode field
//////////////////////////////

// Width of the opcode, 16 codes of which 14 are named
`define ALU_OP_BITS 4

`endif
